// File: axi4s_pipe_auto.sv
`timescale 1ns/1ps

module axi4s_pipe_auto #(
    parameter int DATA_BYTE_WID   = axi4s_pipe_pkg::AXIS_DATA_BYTE_WID_DEFAULT,
    parameter int TID_WID         = axi4s_pipe_pkg::AXIS_TID_WID_DEFAULT,
    parameter int TDEST_WID       = axi4s_pipe_pkg::AXIS_TDEST_WID_DEFAULT,
    parameter int TUSER_WID       = axi4s_pipe_pkg::AXIS_TUSER_WID_DEFAULT,
    parameter int FWD_AUTO_STAGES = 0,
    parameter int REV_AUTO_STAGES = 0,
    parameter bit IGNORE_TREADY   = 1'b0
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    // Input stream
    input  logic                       in_tvalid,
    output logic                       in_tready,
    input  logic [DATA_BYTE_WID*8-1:0] in_tdata,
    input  logic [DATA_BYTE_WID-1:0]   in_tkeep,
    input  logic                       in_tlast,
    input  logic [TID_WID-1:0]         in_tid,
    input  logic [TDEST_WID-1:0]       in_tdest,
    input  logic [TUSER_WID-1:0]       in_tuser,
    // Output stream
    output logic                       out_tvalid,
    input  logic                       out_tready,
    output logic [DATA_BYTE_WID*8-1:0] out_tdata,
    output logic [DATA_BYTE_WID-1:0]   out_tkeep,
    output logic                       out_tlast,
    output logic [TID_WID-1:0]         out_tid,
    output logic [TDEST_WID-1:0]       out_tdest,
    output logic [TUSER_WID-1:0]       out_tuser
);
    import axi4s_pipe_pkg::*;

    localparam int PAYLOAD_WID = payload_wid(DATA_BYTE_WID, TID_WID, TDEST_WID, TUSER_WID);

    // Added stages are capped at what the pipeline supports
    localparam int FWD_AUTO = (FWD_AUTO_STAGES > PIPE_MAX_AUTO_STAGES) ?
                              PIPE_MAX_AUTO_STAGES : FWD_AUTO_STAGES;
    localparam int REV_AUTO = (REV_AUTO_STAGES > PIPE_MAX_AUTO_STAGES) ?
                              PIPE_MAX_AUTO_STAGES : REV_AUTO_STAGES;

    localparam int FWD_STAGES = PIPE_FIXED_STAGES + FWD_AUTO;
    localparam int REV_STAGES = PIPE_FIXED_STAGES + REV_AUTO;

    logic [PAYLOAD_WID-1:0] in_payload;
    logic [PAYLOAD_WID-1:0] out_payload;

    // Pack fields with tdata in the low bits
    assign in_payload = {in_tuser, in_tdest, in_tid, in_tlast, in_tkeep, in_tdata};

    bus_pipe_auto #(
        .DATA_WID     ( PAYLOAD_WID ),
        .FWD_STAGES   ( FWD_STAGES ),
        .REV_STAGES   ( REV_STAGES ),
        .IGNORE_READY ( IGNORE_TREADY )
    ) i_bus_pipe_auto (
        .aclk      ( aclk ),
        .arst_n    ( arst_n ),
        .in_valid  ( in_tvalid ),
        .in_ready  ( in_tready ),
        .in_data   ( in_payload ),
        .out_valid ( out_tvalid ),
        .out_ready ( out_tready ),
        .out_data  ( out_payload )
    );

    // Unpack in the same order
    assign {out_tuser, out_tdest, out_tid, out_tlast, out_tkeep, out_tdata} = out_payload;

endmodule : axi4s_pipe_auto

// File: axi4s_pipe_pkg.sv
package axi4s_pipe_pkg;

    // Default AXI4-Stream field widths
    localparam int AXIS_DATA_BYTE_WID_DEFAULT = 4;
    localparam int AXIS_TID_WID_DEFAULT       = 2;
    localparam int AXIS_TDEST_WID_DEFAULT     = 3;
    localparam int AXIS_TUSER_WID_DEFAULT     = 4;

    // Stages always present in each direction
    localparam int PIPE_FIXED_STAGES    = 2;
    // Upper bound on added stages per direction
    localparam int PIPE_MAX_AUTO_STAGES = 11;

    // Width of the packed payload carried through the pipeline
    // tdata (8 bits/byte) + tkeep (1 bit/byte) + tlast + sideband fields
    function automatic int payload_wid(
        input int data_byte_wid,
        input int tid_wid,
        input int tdest_wid,
        input int tuser_wid
    );
        return data_byte_wid*9 + 1 + tid_wid + tdest_wid + tuser_wid;
    endfunction

    // Elastic buffer depth for a given round trip
    // Must cover every beat in flight, rounded up to a power of two
    function automatic int fifo_depth(
        input int fwd_stages,
        input int rev_stages
    );
        int n;
        n = fwd_stages + rev_stages + 2;
        return 2**$clog2(n);
    endfunction

endpackage : axi4s_pipe_pkg

// File: bus_pipe_auto.sv
`timescale 1ns/1ps

module bus_pipe_auto #(
    parameter int DATA_WID     = 32,
    parameter int FWD_STAGES   = axi4s_pipe_pkg::PIPE_FIXED_STAGES,
    parameter int REV_STAGES   = axi4s_pipe_pkg::PIPE_FIXED_STAGES,
    parameter bit IGNORE_READY = 1'b0
) (
    input  logic                aclk,
    input  logic                arst_n,
    // Upstream side
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [DATA_WID-1:0] in_data,
    // Downstream side
    output logic                out_valid,
    input  logic                out_ready,
    output logic [DATA_WID-1:0] out_data
);
    import axi4s_pipe_pkg::*;

    localparam int FIFO_DEPTH   = fifo_depth(FWD_STAGES, REV_STAGES);
    // One more than the beats that can still land after space drops
    localparam int SPACE_THRESH = FWD_STAGES + REV_STAGES + 1;

    logic                in_accept;
    logic [FWD_STAGES-1:0] fwd_valid;
    logic [DATA_WID-1:0] fwd_data [FWD_STAGES];

    // Only beats that completed the input handshake enter the chain
    assign in_accept = in_valid && in_ready;

    // Forward valid chain that never stalls
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fwd_valid <= '0;
        end
        else
        begin
            fwd_valid[0] <= in_accept;
            for (int i = 1; i < FWD_STAGES; i++)
            begin
                fwd_valid[i] <= fwd_valid[i-1];
            end
        end
    end

    // Forward payload chain
    always_ff @(posedge aclk)
    begin
        fwd_data[0] <= in_data;
        for (int i = 1; i < FWD_STAGES; i++)
        begin
            fwd_data[i] <= fwd_data[i-1];
        end
    end

    generate
        if (IGNORE_READY)
        begin : g_no_fifo
            // Sink never stalls, so the tail of the chain is the output
            assign in_ready  = 1'b1;
            assign out_valid = fwd_valid[FWD_STAGES-1];
            assign out_data  = fwd_data[FWD_STAGES-1];
        end
        else
        begin : g_fifo
            logic                  space;
            logic [REV_STAGES-1:0] rev_ready;

            // Reverse ready chain is low out of reset
            always_ff @(posedge aclk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    rev_ready <= '0;
                end
                else
                begin
                    rev_ready[0] <= space;
                    for (int i = 1; i < REV_STAGES; i++)
                    begin
                        rev_ready[i] <= rev_ready[i-1];
                    end
                end
            end

            assign in_ready = rev_ready[REV_STAGES-1];

            // Absorbs everything still in flight when the sink stalls
            bus_pipe_fifo #(
                .DATA_WID     ( DATA_WID ),
                .DEPTH        ( FIFO_DEPTH ),
                .SPACE_THRESH ( SPACE_THRESH )
            ) i_bus_pipe_fifo (
                .aclk     ( aclk ),
                .arst_n   ( arst_n ),
                .wr_valid ( fwd_valid[FWD_STAGES-1] ),
                .wr_data  ( fwd_data[FWD_STAGES-1] ),
                .rd_ready ( out_ready ),
                .rd_valid ( out_valid ),
                .rd_data  ( out_data ),
                .space    ( space )
            );
        end
    endgenerate

endmodule : bus_pipe_auto

// File: bus_pipe_fifo.sv
`timescale 1ns/1ps

module bus_pipe_fifo #(
    parameter int DATA_WID     = 32,
    parameter int DEPTH        = 8,
    parameter int SPACE_THRESH = 5
) (
    input  logic                aclk,
    input  logic                arst_n,
    // Write side without back-pressure
    input  logic                wr_valid,
    input  logic [DATA_WID-1:0] wr_data,
    // Read side
    input  logic                rd_ready,
    output logic                rd_valid,
    output logic [DATA_WID-1:0] rd_data,
    // Early room indication for the reverse path
    output logic                space
);
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH) + 2;

    logic [DATA_WID-1:0] mem [DEPTH];

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] count_nxt;
    logic [CNT_WID-1:0] occ_nxt;

    logic load_out;
    logic mem_empty;
    logic bypass;
    logic push_mem;
    logic pop_mem;
    logic rd_valid_nxt;
    logic space_nxt;

    // Output register can take a new entry when empty or being consumed
    assign load_out  = !rd_valid || rd_ready;
    assign mem_empty = (count == '0);

    // Write goes straight to the output register when nothing older is stored
    assign bypass   = load_out && mem_empty && wr_valid;
    assign push_mem = wr_valid && !bypass;
    assign pop_mem  = load_out && !mem_empty;

    assign rd_valid_nxt = load_out ? (!mem_empty || wr_valid) : rd_valid;

    always_comb
    begin
        count_nxt = count + CNT_WID'(push_mem) - CNT_WID'(pop_mem);
        // Occupancy includes the beat held in the output register
        occ_nxt   = count_nxt + CNT_WID'(rd_valid_nxt);
    end

    assign space_nxt = (int'(occ_nxt) + SPACE_THRESH) <= DEPTH;

    // Storage array
    always_ff @(posedge aclk)
    begin
        if (push_mem)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers, count and status
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
            space    <= 1'b0;
        end
        else
        begin
            if (push_mem)
            begin
                wr_ptr <= wr_ptr + PTR_WID'(1);
            end
            if (pop_mem)
            begin
                rd_ptr <= rd_ptr + PTR_WID'(1);
            end
            count    <= count_nxt;
            rd_valid <= rd_valid_nxt;
            space    <= space_nxt;
        end
    end

    // Registered head of the buffer
    always_ff @(posedge aclk)
    begin
        if (pop_mem)
        begin
            rd_data <= mem[rd_ptr];
        end
        else if (bypass)
        begin
            rd_data <= wr_data;
        end
    end

endmodule : bus_pipe_fifo

// File: run.sh
#!/bin/sh
# Compile and run the AXI4-Stream pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_axi4s_pipe_auto \
    --Mdir obj_dir -o tb_axi4s_pipe_auto

out=$(./obj_dir/tb_axi4s_pipe_auto 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="
then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: src.f
axi4s_pipe_pkg.sv
bus_pipe_fifo.sv
bus_pipe_auto.sv
axi4s_pipe_auto.sv
tb_axi4s_checker.sv
tb_axi4s_pipe_auto.sv

// File: tb_axi4s_checker.sv
`timescale 1ns/1ps

module tb_axi4s_checker #(
    parameter int DATA_BYTE_WID = 4,
    parameter int TID_WID       = 2,
    parameter int TDEST_WID     = 3,
    parameter int TUSER_WID     = 4,
    parameter int PAYLOAD_WID   = 46
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    input  logic                       in_tvalid,
    input  logic                       in_tready,
    input  logic                       out_tvalid,
    input  logic                       out_tready,
    input  logic [DATA_BYTE_WID*8-1:0] out_tdata,
    input  logic [DATA_BYTE_WID-1:0]   out_tkeep,
    input  logic                       out_tlast,
    input  logic [TID_WID-1:0]         out_tid,
    input  logic [TDEST_WID-1:0]       out_tdest,
    input  logic [TUSER_WID-1:0]       out_tuser,
    // Expected beat for exp_idx as built by the testbench top
    input  logic [PAYLOAD_WID-1:0]     exp_beat,
    output int                         exp_idx,
    output int                         in_count,
    output int                         out_count,
    output int                         err_count
);
    // Field offsets inside the expected beat vector
    localparam int KEEP_LSB = DATA_BYTE_WID*8;
    localparam int LAST_BIT = KEEP_LSB + DATA_BYTE_WID;
    localparam int ID_LSB   = LAST_BIT + 1;
    localparam int DEST_LSB = ID_LSB + TID_WID;
    localparam int USER_LSB = DEST_LSB + TDEST_WID;

    int idx_q[$];
    int head_idx = 0;
    int n_in     = 0;
    int n_out    = 0;
    int n_err    = 0;

    assign exp_idx   = head_idx;
    assign in_count  = n_in;
    assign out_count = n_out;
    assign err_count = n_err;

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t ns: beat %0d field %s got %0h expected %0h",
                     $time, head_idx, name, got, exp);
            n_err++;
        end
    endtask

    // Sampled on the falling edge where every handshake signal is settled
    always @(negedge aclk)
    begin
        if (arst_n)
        begin
            if (out_tvalid && out_tready)
            begin
                if (idx_q.size() == 0)
                begin
                    $display("Output beat at %0t ns with no accepted input beat left to match",
                             $time);
                    n_err++;
                end
                else
                begin
                    compare_field("tdata", 64'(out_tdata), 64'(exp_beat[KEEP_LSB-1:0]));
                    compare_field("tkeep", 64'(out_tkeep), 64'(exp_beat[LAST_BIT-1:KEEP_LSB]));
                    compare_field("tlast", 64'(out_tlast), 64'(exp_beat[LAST_BIT]));
                    compare_field("tid", 64'(out_tid), 64'(exp_beat[DEST_LSB-1:ID_LSB]));
                    compare_field("tdest", 64'(out_tdest), 64'(exp_beat[USER_LSB-1:DEST_LSB]));
                    compare_field("tuser", 64'(out_tuser), 64'(exp_beat[PAYLOAD_WID-1:USER_LSB]));
                    void'(idx_q.pop_front());
                end
                n_out++;
            end
            if (in_tvalid && in_tready)
            begin
                idx_q.push_back(n_in);
                n_in++;
            end
            // Oldest beat still owed to the sink
            if (idx_q.size() != 0)
            begin
                head_idx = idx_q[0];
            end
        end
    end

endmodule : tb_axi4s_checker

// File: tb_axi4s_pipe_auto.sv
`timescale 1ns/1ps

module tb_axi4s_pipe_auto;
    localparam int DATA_BYTE_WID   = 4;
    localparam int TID_WID         = 2;
    localparam int TDEST_WID       = 3;
    localparam int TUSER_WID       = 4;
    localparam int FWD_AUTO_STAGES = 3;
    localparam int REV_AUTO_STAGES = 1;

    localparam int DW          = DATA_BYTE_WID*8;
    localparam int PAYLOAD_WID = DW + DATA_BYTE_WID + 1 + TID_WID + TDEST_WID + TUSER_WID;
    localparam int FWD_STAGES  = axi4s_pipe_pkg::PIPE_FIXED_STAGES + FWD_AUTO_STAGES;
    localparam int REV_STAGES  = axi4s_pipe_pkg::PIPE_FIXED_STAGES + REV_AUTO_STAGES;
    // Round trip plus two, rounded up to a power of two
    localparam int BUF_DEPTH   = 2**$clog2(FWD_STAGES + REV_STAGES + 2);

    localparam int THRU_BEATS     = 64;
    localparam int RANDOM_BEATS   = 400;
    localparam int STALL_BEATS    = 40;
    localparam int STALL_CYCLES   = 40;
    localparam int TOTAL_BEATS    = 1 + THRU_BEATS + RANDOM_BEATS + STALL_BEATS;
    localparam int TIMEOUT_CYCLES = 2*TOTAL_BEATS + 200;

    logic                     aclk;
    logic                     arst_n;
    logic                     in_tvalid;
    logic                     in_tready;
    logic [DW-1:0]            in_tdata;
    logic [DATA_BYTE_WID-1:0] in_tkeep;
    logic                     in_tlast;
    logic [TID_WID-1:0]       in_tid;
    logic [TDEST_WID-1:0]     in_tdest;
    logic [TUSER_WID-1:0]     in_tuser;
    logic                     out_tvalid;
    logic                     out_tready;
    logic [DW-1:0]            out_tdata;
    logic [DATA_BYTE_WID-1:0] out_tkeep;
    logic                     out_tlast;
    logic [TID_WID-1:0]       out_tid;
    logic [TDEST_WID-1:0]     out_tdest;
    logic [TUSER_WID-1:0]     out_tuser;

    logic [PAYLOAD_WID-1:0]   exp_beat;
    int                       exp_idx;
    int                       in_count;
    int                       out_count;
    int                       chk_errs;

    integer seed         = 32'hc419_c593;
    // 0 holds out_tready low, 1 holds it high, 2 randomizes it
    int     ready_mode   = 1;
    int     top_errs     = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     cycles       = 0;

    // Reference beat for an index
    function automatic logic [PAYLOAD_WID-1:0] make_beat(input int idx);
        logic [DW-1:0]            data;
        logic [DATA_BYTE_WID-1:0] keep;
        logic                     last;
        logic [TID_WID-1:0]       id;
        logic [TDEST_WID-1:0]     dest;
        logic [TUSER_WID-1:0]     user;
        data = DW'((idx * 32'h0001_0001) ^ 32'h5a00_00c3);
        last = (idx % 8) == 7;
        keep = '1;
        // Every second packet ends on a short beat
        if (last && idx[3])
        begin
            keep = keep >> (1 + idx[4]);
        end
        id   = TID_WID'(idx >> 3);
        dest = TDEST_WID'(idx >> 1);
        user = TUSER_WID'(idx ^ (idx >> 5));
        return {user, dest, id, last, keep, data};
    endfunction

    assign exp_beat = make_beat(exp_idx);

    axi4s_pipe_auto #(
        .DATA_BYTE_WID   ( DATA_BYTE_WID ),
        .TID_WID         ( TID_WID ),
        .TDEST_WID       ( TDEST_WID ),
        .TUSER_WID       ( TUSER_WID ),
        .FWD_AUTO_STAGES ( FWD_AUTO_STAGES ),
        .REV_AUTO_STAGES ( REV_AUTO_STAGES ),
        .IGNORE_TREADY   ( 1'b0 )
    ) i_dut (
        .aclk       ( aclk ),
        .arst_n     ( arst_n ),
        .in_tvalid  ( in_tvalid ),
        .in_tready  ( in_tready ),
        .in_tdata   ( in_tdata ),
        .in_tkeep   ( in_tkeep ),
        .in_tlast   ( in_tlast ),
        .in_tid     ( in_tid ),
        .in_tdest   ( in_tdest ),
        .in_tuser   ( in_tuser ),
        .out_tvalid ( out_tvalid ),
        .out_tready ( out_tready ),
        .out_tdata  ( out_tdata ),
        .out_tkeep  ( out_tkeep ),
        .out_tlast  ( out_tlast ),
        .out_tid    ( out_tid ),
        .out_tdest  ( out_tdest ),
        .out_tuser  ( out_tuser )
    );

    tb_axi4s_checker #(
        .DATA_BYTE_WID ( DATA_BYTE_WID ),
        .TID_WID       ( TID_WID ),
        .TDEST_WID     ( TDEST_WID ),
        .TUSER_WID     ( TUSER_WID ),
        .PAYLOAD_WID   ( PAYLOAD_WID )
    ) i_checker (
        .aclk       ( aclk ),
        .arst_n     ( arst_n ),
        .in_tvalid  ( in_tvalid ),
        .in_tready  ( in_tready ),
        .out_tvalid ( out_tvalid ),
        .out_tready ( out_tready ),
        .out_tdata  ( out_tdata ),
        .out_tkeep  ( out_tkeep ),
        .out_tlast  ( out_tlast ),
        .out_tid    ( out_tid ),
        .out_tdest  ( out_tdest ),
        .out_tuser  ( out_tuser ),
        .exp_beat   ( exp_beat ),
        .exp_idx    ( exp_idx ),
        .in_count   ( in_count ),
        .out_count  ( out_count ),
        .err_count  ( chk_errs )
    );

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // Sink side takes the mode at the edge and applies it 2 ns later
    initial
    begin
        int mode;
        out_tready = 1'b0;
        forever
        begin
            @(posedge aclk);
            mode = ready_mode;
            #2;
            case (mode)
                0:       out_tready = 1'b0;
                1:       out_tready = 1'b1;
                default: out_tready = (($random(seed) & 3) != 0);
            endcase
        end
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int error_total();
        return top_errs + chk_errs;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = error_total() - errs_before;
        tests_run++;
        if (errs == 0)
        begin
            $display("Test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errs);
        end
    endtask

    // Starts and ends 2 ns after a rising edge and holds the beat until accepted
    task automatic send_beat(input int idx, input bit gaps);
        logic accepted;
        if (gaps)
        begin
            while (($random(seed) & 3) == 0)
            begin
                @(posedge aclk);
                #2;
            end
        end
        {in_tuser, in_tdest, in_tid, in_tlast, in_tkeep, in_tdata} = make_beat(idx);
        in_tvalid = 1'b1;
        accepted  = 1'b0;
        while (!accepted)
        begin
            @(negedge aclk);
            accepted = in_tready;
            @(posedge aclk);
            #2;
        end
        in_tvalid = 1'b0;
    endtask

    task automatic send_beats(input int first, input int count, input bit gaps);
        for (int i = 0; i < count; i++)
        begin
            send_beat(first + i, gaps);
        end
    endtask

    task automatic wait_drain();
        while (out_count != in_count)
        begin
            @(posedge aclk);
            #2;
        end
    endtask

    initial
    begin
        int   n;
        int   lat;
        int   mark;
        int   first;
        int   last;
        int   n_out;
        int   start_in;
        logic rdy;
        logic seen;

        arst_n    = 1'b0;
        in_tvalid = 1'b0;
        in_tdata  = '0;
        in_tkeep  = '0;
        in_tlast  = 1'b0;
        in_tid    = '0;
        in_tdest  = '0;
        in_tuser  = '0;
        repeat (2) @(posedge aclk);
        #2;
        arst_n = 1'b1;

        // in_tready must follow the reverse chain out of reset
        mark = error_total();
        n    = 0;
        rdy  = 1'b0;
        while (!rdy && n < 20)
        begin
            @(posedge aclk);
            n++;
            @(negedge aclk);
            rdy = in_tready;
            if (out_tvalid)
            begin
                $display("Error at %0t ns: out_tvalid high after reset", $time);
                top_errs++;
            end
        end
        if (n != REV_STAGES + 1)
        begin
            $display("Error at %0t ns: in_tready rose %0d cycles after reset, expected %0d",
                     $time, n, REV_STAGES + 1);
            top_errs++;
        end
        @(posedge aclk);
        #2;
        report_test("reset_state", mark);

        // Edges from input handshake to output handshake
        mark = error_total();
        send_beat(0, 1'b0);
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < 50)
        begin
            @(negedge aclk);
            lat++;
            seen = out_tvalid && out_tready;
        end
        if (lat != FWD_STAGES + 1)
        begin
            $display("Error at %0t ns: latency %0d cycles, expected %0d",
                     $time, lat, FWD_STAGES + 1);
            top_errs++;
        end
        @(posedge aclk);
        #2;
        wait_drain();
        report_test("latency", mark);

        mark = error_total();
        fork
            send_beats(1, THRU_BEATS, 1'b0);
            begin
                n_out = 0;
                n     = 0;
                first = 0;
                last  = 0;
                while (n_out < THRU_BEATS)
                begin
                    @(negedge aclk);
                    n++;
                    if (out_tvalid && out_tready)
                    begin
                        if (n_out == 0)
                        begin
                            first = n;
                        end
                        last = n;
                        n_out++;
                    end
                end
            end
        join
        @(posedge aclk);
        #2;
        wait_drain();
        if (last - first + 1 != THRU_BEATS)
        begin
            $display("Error at %0t ns: %0d beats took %0d cycles at the output",
                     $time, THRU_BEATS, last - first + 1);
            top_errs++;
        end
        report_test("full_throughput", mark);

        mark       = error_total();
        ready_mode = 2;
        send_beats(1 + THRU_BEATS, RANDOM_BEATS, 1'b1);
        ready_mode = 1;
        wait_drain();
        // Buffer must be empty once every accepted beat has left
        if (out_tvalid)
        begin
            $display("Error at %0t ns: out_tvalid still high after all %0d beats were delivered",
                     $time, out_count);
            top_errs++;
        end
        report_test("random_stalls", mark);

        mark       = error_total();
        ready_mode = 0;
        @(posedge aclk);
        #2;
        start_in = in_count;
        fork
            send_beats(1 + THRU_BEATS + RANDOM_BEATS, STALL_BEATS, 1'b0);
            begin
                repeat (STALL_CYCLES) @(posedge aclk);
                #2;
                if (in_count - start_in > BUF_DEPTH || !out_tvalid)
                begin
                    $display("Error at %0t ns: %0d beats in during stall, depth %0d, out_tvalid %0b",
                             $time, in_count - start_in, BUF_DEPTH, out_tvalid);
                    top_errs++;
                end
                ready_mode = 1;
            end
        join
        wait_drain();
        if (out_tvalid)
        begin
            $display("Error at %0t ns: out_tvalid still high after all %0d beats were delivered",
                     $time, out_count);
            top_errs++;
        end
        report_test("long_stall", mark);

        $display("Summary: %0d tests, %0d failed, %0d beats in, %0d beats out, %0d errors",
                 tests_run, tests_failed, in_count, out_count, error_total());
        if (error_total() == 0 && tests_failed == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_axi4s_pipe_auto
